// File: sim.f
+incdir+hw
+incdir+tb
hw/rv32_pkg.sv
hw/rv32_register_file.sv
hw/rv32_fetch_stage.sv
hw/rv32_decode_stage.sv
hw/rv32_exec_stage.sv
hw/rv32_mem_stage.sv
hw/rv32_core.sv
tb/tb_rv32_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the RV32 core testbench with Verilator and run it.
# The run fails if the build or simulation fails or the log holds the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_rv32_core \
    -o tb_rv32_core > build.log 2>&1 \
    && ./obj_dir/tb_rv32_core > sim.log 2>&1 \
    && ! grep -q "STATUS: FAIL" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: tb/rv32_test_table.svh
// ----------------------------------------
// Test program and expected retired writes
// for the core testbench. Include inside
// the testbench module body
// ----------------------------------------
`ifndef RV32_TEST_TABLE_SVH
`define RV32_TEST_TABLE_SVH

localparam int PROG_LEN = 36;
localparam int EXP_LEN  = 20;

typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] value;
} retire_entry_t;

// Word i sits at byte address 4*i
// Wrong-path words load 0x222..0x777, which must never retire
localparam logic [31:0] PROG [PROG_LEN] = '{
    32'h0050_0093,  // 0   addi x1, x0, 5
    32'hffd0_0113,  // 1   addi x2, x0, -3
    32'h0020_81b3,  // 2   add  x3, x1, x2
    32'h4020_8233,  // 3   sub  x4, x1, x2
    32'h00c2_7293,  // 4   andi x5, x4, 12
    32'h0032_e313,  // 5   ori  x6, x5, 3
    32'hfff3_4393,  // 6   xori x7, x6, -1
    32'h0013_f433,  // 7   and  x8, x7, x1
    32'h0034_64b3,  // 8   or   x9, x8, x3
    32'h0044_c533,  // 9   xor  x10, x9, x4
    32'h1234_55b7,  // 10  lui  x11, 0x12345
    32'h6785_8593,  // 11  addi x11, x11, 0x678
    32'h0070_8013,  // 12  addi x0, x1, 7
    32'h0010_8033,  // 13  add  x0, x1, x1
    32'h0030_8463,  // 14  beq  x1, x3, +8   (not taken)
    32'h0010_0613,  // 15  addi x12, x0, 1
    32'h00c6_0663,  // 16  beq  x12, x12, +12
    32'h6660_0693,  // 17  addi x13, x0, 0x666
    32'h7770_0693,  // 18  addi x13, x0, 0x777
    32'h0030_9663,  // 19  bne  x1, x3, +12
    32'h5550_0713,  // 20  addi x14, x0, 0x555
    32'h4440_0713,  // 21  addi x14, x0, 0x444
    32'h0010_9463,  // 22  bne  x1, x1, +8   (not taken)
    32'h0020_0793,  // 23  addi x15, x0, 2
    32'h00c0_086f,  // 24  jal  x16, +12
    32'h3330_0893,  // 25  addi x17, x0, 0x333
    32'h2220_0893,  // 26  addi x17, x0, 0x222
    32'h0400_0913,  // 27  addi x18, x0, 0x40
    32'h00b9_2023,  // 28  sw   x11, 0(x18)
    32'h00a9_2223,  // 29  sw   x10, 4(x18)
    32'h0009_2983,  // 30  lw   x19, 0(x18)
    32'h0049_2a03,  // 31  lw   x20, 4(x18)
    32'h0029_2423,  // 32  sw   x2, 8(x18)
    32'h0089_2a83,  // 33  lw   x21, 8(x18)
    32'h0149_8b33,  // 34  add  x22, x19, x20
    32'h0000_006f   // 35  jal  x0, 0        (park here)
};

// Register writes in program order
localparam retire_entry_t EXPECTED [EXP_LEN] = '{
    '{5'd1,  32'h0000_0005},
    '{5'd2,  32'hffff_fffd},
    '{5'd3,  32'h0000_0002},
    '{5'd4,  32'h0000_0008},
    '{5'd5,  32'h0000_0008},
    '{5'd6,  32'h0000_000b},
    '{5'd7,  32'hffff_fff4},
    '{5'd8,  32'h0000_0004},
    '{5'd9,  32'h0000_0006},
    '{5'd10, 32'h0000_000e},
    '{5'd11, 32'h1234_5000},
    '{5'd11, 32'h1234_5678},
    '{5'd12, 32'h0000_0001},
    '{5'd15, 32'h0000_0002},
    '{5'd16, 32'h0000_0064},
    '{5'd18, 32'h0000_0040},
    '{5'd19, 32'h1234_5678},
    '{5'd20, 32'h0000_000e},
    '{5'd21, 32'hffff_fffd},
    '{5'd22, 32'h1234_5686}
};

`endif

// File: tb/tb_rv32_core.sv
// ----------------------------------------
// Testbench for the RV32 core
// Runs the test program twice, first with
// a steady instruction port, then with
// random ready gaps, and checks every
// retired register write
// ----------------------------------------
`timescale 1ns/1ps
`include "rv32_cfg.svh"

module tb_rv32_core;
    import rv32_pkg::*;

    `include "rv32_test_table.svh"

    localparam int          WAIT_LIMIT  = 200;
    localparam int          IDLE_WINDOW = 60;
    localparam logic [31:0] NOP_WORD    = 32'h0000_0013;
    localparam logic [31:0] LFSR_SEED   = 32'h53b6_3622;

    logic                 clk;
    logic                 resetn;
    rv_instr_t            instr_bus;
    logic                 instr_ready = 1'b1;
    rv32_word             instr_addr;
    rv32_word             pc;
    fetch_buffer_data_t   instr_buff_data;
    decoded_buffer_data_t decoded_buff_data;
    exec_buffer_data_t    exec_buff_data;
    mem_buffer_data_t     mem_buff_data;

    logic                 gaps_on    = 1'b0;
    logic [31:0]          lfsr_state = LFSR_SEED;
    logic [31:0]          lfsr_next;
    logic                 in_range;
    logic [5:0]           rom_idx;
    int                   mismatches;
    int                   timeouts;
    int                   unexpected;

    rv32_core u_rv32_core (
        .clk               (clk),
        .resetn            (resetn),
        .instr_bus         (instr_bus),
        .instr_ready       (instr_ready),
        .instr_addr        (instr_addr),
        .pc                (pc),
        .instr_buff_data   (instr_buff_data),
        .decoded_buff_data (decoded_buff_data),
        .exec_buff_data    (exec_buff_data),
        .mem_buff_data     (mem_buff_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Program ROM returns NOPs outside the table
    assign in_range  = instr_addr[31:2] < 30'(PROG_LEN);
    assign rom_idx   = instr_addr[7:2];
    assign instr_bus = in_range ? PROG[rom_idx] : NOP_WORD;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One LFSR bit per cycle decides whether the port is ready
    always @(negedge clk) begin
        lfsr_next = lfsr_step(lfsr_state);
        if (gaps_on) begin
            lfsr_state  <= lfsr_next;
            instr_ready <= lfsr_next[0];
        end else begin
            instr_ready <= 1'b1;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_reset_state();
        compare_value("pc", `RV32_RESET_PC, pc);
        compare_value("instr_addr", `RV32_RESET_PC, instr_addr);
        compare_value("instr_buff_data.valid", 32'd0, 32'(instr_buff_data.valid));
        compare_value("decoded_buff_data.valid", 32'd0, 32'(decoded_buff_data.valid));
        compare_value("exec_buff_data.valid", 32'd0, 32'(exec_buff_data.valid));
        compare_value("mem_buff_data.valid", 32'd0, 32'(mem_buff_data.valid));
        compare_value("mem_buff_data.reg_write", 32'd0, 32'(mem_buff_data.reg_write));
    endtask

    // Waits on falling edges for the next retiring register write
    task automatic wait_for_write(output mem_buffer_data_t seen, output logic found);
        int cycles;
        found  = 1'b0;
        seen   = '0;
        cycles = 0;
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (mem_buff_data.valid && mem_buff_data.reg_write) begin
                found = 1'b1;
                seen  = mem_buff_data;
            end
        end
    endtask

    task automatic check_quiet_window();
        for (int c = 0; c < IDLE_WINDOW; c++) begin
            @(negedge clk);
            if (mem_buff_data.valid && mem_buff_data.reg_write) begin
                $display("Unexpected register write after the program ended: x%0d = %h at t=%0t",
                         mem_buff_data.rd, mem_buff_data.result, $time);
                unexpected++;
            end
        end
    endtask

    task automatic run_program(input logic with_gaps);
        mem_buffer_data_t seen;
        retire_entry_t    expected;
        logic             found;
        logic             aborted;
        @(negedge clk);
        resetn  = 1'b0;
        gaps_on <= with_gaps;
        repeat (5) @(negedge clk);
        check_reset_state();
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        // Still the reset values until the next rising edge
        check_reset_state();
        aborted = 1'b0;
        for (int i = 0; i < EXP_LEN && !aborted; i++) begin
            expected = EXPECTED[i[4:0]];
            wait_for_write(seen, found);
            if (!found) begin
                $display("Timed out waiting for write %0d (x%0d), ready gaps %0s, at t=%0t",
                         i, expected.rd, with_gaps ? "on" : "off", $time);
                timeouts++;
                aborted = 1'b1;
            end else begin
                compare_value("mem_buff_data.rd", 32'(expected.rd), 32'(seen.rd));
                compare_value("mem_buff_data.result", expected.value, seen.result);
            end
        end
        if (!aborted) begin
            check_quiet_window();
        end
    endtask

    initial begin
        resetn     = 1'b0;
        mismatches = 0;
        timeouts   = 0;
        unexpected = 0;
        run_program(1'b0);
        run_program(1'b1);
        $display("Errors: mismatches=%0d timeouts=%0d unexpected_writes=%0d",
                 mismatches, timeouts, unexpected);
        if (mismatches + timeouts + unexpected == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: hw/rv32_core.sv
// ----------------------------------------
// RV32 five-stage core, top level
// Instruction port in, stage records out
// as debug ports for the testbench
// ----------------------------------------
`timescale 1ns/1ps
`include "rv32_cfg.svh"

module rv32_core (
    input  logic                           clk,
    input  logic                           resetn,
    input  rv32_pkg::rv_instr_t            instr_bus,
    input  logic                           instr_ready,
    output rv32_pkg::rv32_word             instr_addr,
    output rv32_pkg::rv32_word             pc,
    output rv32_pkg::fetch_buffer_data_t   instr_buff_data,
    output rv32_pkg::decoded_buffer_data_t decoded_buff_data,
    output rv32_pkg::exec_buffer_data_t    exec_buff_data,
    output rv32_pkg::mem_buffer_data_t     mem_buff_data
);
    import rv32_pkg::*;

    logic       exec_jump;
    rv32_word   exec_jump_addr;
    logic       dec_stall;
    rv_reg_id_t dec_rs1;
    rv_reg_id_t dec_rs2;
    rv32_word   dec_reg1;
    rv32_word   dec_reg2;
    logic       wb_we;

    // Jump beats stall; pc only moves when a word is accepted
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= `RV32_RESET_PC;
        end else if (exec_jump) begin
            pc <= exec_jump_addr;
        end else if (!dec_stall && instr_ready) begin
            pc <= pc + 32'd4;
        end
    end

    assign wb_we = mem_buff_data.valid && mem_buff_data.reg_write;

    rv32_register_file u_register_file (
        .clk    (clk),
        .resetn (resetn),
        .r1     (dec_rs1),
        .r2     (dec_rs2),
        .rw     (mem_buff_data.rd),
        .write  (wb_we),
        .d      (mem_buff_data.result),
        .o1     (dec_reg1),
        .o2     (dec_reg2)
    );

    rv32_fetch_stage u_fetch_stage (
        .clk        (clk),
        .resetn     (resetn),
        .pc         (pc),
        .stall      (dec_stall),
        .flush      (exec_jump),
        .instr      (instr_bus),
        .ready      (instr_ready),
        .addr       (instr_addr),
        .fetch_data (instr_buff_data)
    );

    // Hazard check sees the execute and memory inputs
    rv32_decode_stage u_decode_stage (
        .clk          (clk),
        .resetn       (resetn),
        .instr_data   (instr_buff_data),
        .flush        (exec_jump),
        .reg1         (dec_reg1),
        .reg2         (dec_reg2),
        .exec_rd_busy (decoded_buff_data),
        .mem_rd_busy  (exec_buff_data),
        .decode_data  (decoded_buff_data),
        .stall        (dec_stall),
        .rs1          (dec_rs1),
        .rs2          (dec_rs2)
    );

    rv32_exec_stage u_exec_stage (
        .clk          (clk),
        .resetn       (resetn),
        .decoded_data (decoded_buff_data),
        .exec_data    (exec_buff_data),
        .do_jump      (exec_jump),
        .jump_addr    (exec_jump_addr)
    );

    rv32_mem_stage u_mem_stage (
        .clk       (clk),
        .resetn    (resetn),
        .exec_data (exec_buff_data),
        .mem_data  (mem_buff_data)
    );

    // Jump targets come from execute, so alignment is a whole-core property
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!resetn)
        pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

endmodule

// File: hw/rv32_mem_stage.sv
// ----------------------------------------
// Memory stage with local data RAM
// Word loads and stores only; produces the
// record that writes the register file
// ----------------------------------------
`timescale 1ns/1ps
`include "rv32_cfg.svh"

module rv32_mem_stage (
    input  logic                        clk,
    input  logic                        resetn,
    input  rv32_pkg::exec_buffer_data_t exec_data,
    output rv32_pkg::mem_buffer_data_t  mem_data
);
    import rv32_pkg::*;

    localparam int AW = $clog2(`RV32_DMEM_WORDS);

    rv32_word      dmem [`RV32_DMEM_WORDS];
    logic [AW-1:0] idx;
    rv32_word      load_word;

    // Word address wraps at the RAM depth
    assign idx       = exec_data.result[AW+1:2];
    assign load_word = dmem[idx];

    always_ff @(posedge clk) begin
        if (exec_data.valid && exec_data.is_store) begin
            dmem[idx] <= exec_data.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_data.valid     <= 1'b0;
            mem_data.reg_write <= 1'b0;
        end else begin
            mem_data.valid     <= exec_data.valid;
            mem_data.rd        <= exec_data.rd;
            mem_data.reg_write <= exec_data.reg_write && !exec_data.is_store;
            mem_data.result    <= exec_data.is_load ? load_word : exec_data.result;
        end
    end

endmodule

// File: hw/rv32_exec_stage.sv
// ----------------------------------------
// Execute stage
// ALU, branch decision and jump target;
// do_jump goes straight back to fetch/pc
// ----------------------------------------
`timescale 1ns/1ps

module rv32_exec_stage (
    input  logic                           clk,
    input  logic                           resetn,
    input  rv32_pkg::decoded_buffer_data_t decoded_data,
    output rv32_pkg::exec_buffer_data_t    exec_data,
    output logic                           do_jump,
    output rv32_pkg::rv32_word             jump_addr
);
    import rv32_pkg::*;

    rv32_word          op_b;
    rv32_word          alu_out;
    rv32_word          link;
    logic              equal;
    logic              taken;
    exec_buffer_data_t nxt;

    assign op_b = decoded_data.use_imm ? decoded_data.imm : decoded_data.op2;
    assign link = decoded_data.pc + 32'd4;

    always_comb begin
        case (decoded_data.alu_op)
            ALU_ADD: alu_out = decoded_data.op1 + op_b;
            ALU_SUB: alu_out = decoded_data.op1 - op_b;
            ALU_AND: alu_out = decoded_data.op1 & op_b;
            ALU_OR:  alu_out = decoded_data.op1 | op_b;
            ALU_XOR: alu_out = decoded_data.op1 ^ op_b;
            default: alu_out = op_b;
        endcase
    end

    // BNE inverts the equality test
    assign equal     = decoded_data.op1 == decoded_data.op2;
    assign taken     = decoded_data.is_jal ||
                       (decoded_data.is_branch && (equal != decoded_data.branch_ne));
    assign do_jump   = decoded_data.valid && taken;
    assign jump_addr = decoded_data.pc + decoded_data.imm;

    always_comb begin
        nxt.valid      = decoded_data.valid;
        nxt.rd         = decoded_data.rd;
        nxt.reg_write  = decoded_data.reg_write;
        nxt.is_load    = decoded_data.is_load;
        nxt.is_store   = decoded_data.is_store;
        nxt.result     = decoded_data.is_jal ? link : alu_out;
        nxt.store_data = decoded_data.op2;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exec_data.valid     <= 1'b0;
            exec_data.reg_write <= 1'b0;
        end else begin
            exec_data <= nxt;
        end
    end

    // The record behind a taken jump is on the wrong path
    a_jump_flushes_decode: assert property (
        @(posedge clk) disable iff (!resetn)
        do_jump |=> !decoded_data.valid
    ) else $error("decode record still valid after a jump");

endmodule

// File: hw/rv32_decode_stage.sv
// ----------------------------------------
// Decode stage
// Builds operands and immediates, and
// stalls on hazards with in-flight writes
// ----------------------------------------
`timescale 1ns/1ps

module rv32_decode_stage (
    input  logic                           clk,
    input  logic                           resetn,
    input  rv32_pkg::fetch_buffer_data_t   instr_data,
    input  logic                           flush,
    input  rv32_pkg::rv32_word             reg1,
    input  rv32_pkg::rv32_word             reg2,
    input  rv32_pkg::decoded_buffer_data_t exec_rd_busy,
    input  rv32_pkg::exec_buffer_data_t    mem_rd_busy,
    output rv32_pkg::decoded_buffer_data_t decode_data,
    output logic                           stall,
    output rv32_pkg::rv_reg_id_t           rs1,
    output rv32_pkg::rv_reg_id_t           rs2
);
    import rv32_pkg::*;

    rv_instr_t            ins;
    decoded_buffer_data_t nxt;
    logic                 known;
    logic                 use_rs1;
    logic                 use_rs2;
    rv32_word             imm_i;
    rv32_word             imm_s;
    rv32_word             imm_b;
    rv32_word             imm_u;
    rv32_word             imm_j;

    assign ins = instr_data.instr;
    assign rs1 = ins.r.rs1;
    assign rs2 = ins.r.rs2;

    // Immediate formats, S/B/U/J taken from the R view fields
    assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
    assign imm_s = {{20{ins.r.funct7[6]}}, ins.r.funct7, ins.r.rd};
    assign imm_b = {{19{ins.r.funct7[6]}}, ins.r.funct7[6], ins.r.rd[0],
                    ins.r.funct7[5:0], ins.r.rd[4:1], 1'b0};
    assign imm_u = {ins.r.funct7, ins.r.rs2, ins.r.rs1, ins.r.funct3, 12'h000};
    assign imm_j = {{11{ins.r.funct7[6]}}, ins.r.funct7[6], ins.r.rs1, ins.r.funct3,
                    ins.r.rs2[0], ins.r.funct7[5:0], ins.r.rs2[4:1], 1'b0};

    function automatic alu_op_e funct3_op(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Destination still owed by execute or memory
    function automatic logic pending(input rv_reg_id_t id);
        return id != '0 &&
            ((exec_rd_busy.valid && exec_rd_busy.reg_write && exec_rd_busy.rd == id) ||
             (mem_rd_busy.valid && mem_rd_busy.reg_write && mem_rd_busy.rd == id));
    endfunction

    always_comb begin
        nxt        = '0;
        nxt.pc     = instr_data.pc;
        nxt.rd     = ins.r.rd;
        nxt.op1    = reg1;
        nxt.op2    = reg2;
        nxt.alu_op = ALU_ADD;
        known      = 1'b0;
        use_rs1    = 1'b1;
        use_rs2    = 1'b0;
        case (rv_opcode_e'(ins.r.opcode))
            OPC_OP_IMM: begin
                known         = ins.r.funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};
                nxt.reg_write = 1'b1;
                nxt.use_imm   = 1'b1;
                nxt.imm       = imm_i;
                nxt.alu_op    = funct3_op(ins.r.funct3, 1'b0);
            end
            OPC_OP: begin
                known = (ins.r.funct7 == 7'h00 &&
                         ins.r.funct3 inside {3'b000, 3'b100, 3'b110, 3'b111}) ||
                        (ins.r.funct7 == 7'h20 && ins.r.funct3 == 3'b000);
                use_rs2       = 1'b1;
                nxt.reg_write = 1'b1;
                nxt.alu_op    = funct3_op(ins.r.funct3, ins.r.funct7[5]);
            end
            OPC_LUI: begin
                known         = 1'b1;
                use_rs1       = 1'b0;
                nxt.reg_write = 1'b1;
                nxt.use_imm   = 1'b1;
                nxt.imm       = imm_u;
                nxt.alu_op    = ALU_PASS_B;
            end
            OPC_JAL: begin
                known         = 1'b1;
                use_rs1       = 1'b0;
                nxt.reg_write = 1'b1;
                nxt.is_jal    = 1'b1;
                nxt.imm       = imm_j;
            end
            OPC_BRANCH: begin
                // BEQ and BNE only
                known         = ins.r.funct3[2:1] == 2'b00;
                use_rs2       = 1'b1;
                nxt.is_branch = 1'b1;
                nxt.branch_ne = ins.r.funct3[0];
                nxt.imm       = imm_b;
            end
            OPC_LOAD: begin
                known         = ins.r.funct3 == 3'b010;
                nxt.reg_write = 1'b1;
                nxt.is_load   = 1'b1;
                nxt.use_imm   = 1'b1;
                nxt.imm       = imm_i;
            end
            OPC_STORE: begin
                known        = ins.r.funct3 == 3'b010;
                use_rs2      = 1'b1;
                nxt.is_store = 1'b1;
                nxt.use_imm  = 1'b1;
                nxt.imm      = imm_s;
            end
            default: known = 1'b0;
        endcase
        // Writes to x0 never leave decode
        if (ins.r.rd == '0) begin
            nxt.reg_write = 1'b0;
        end
        nxt.valid = instr_data.valid && known;
    end

    always_comb begin
        stall = instr_data.valid &&
                ((use_rs1 && pending(rs1)) || (use_rs2 && pending(rs2)));
    end

    // Bubble on reset, jump or hazard
    always_ff @(posedge clk) begin
        if (!resetn || flush || stall) begin
            decode_data.valid     <= 1'b0;
            decode_data.reg_write <= 1'b0;
        end else begin
            decode_data <= nxt;
        end
    end

endmodule

// File: hw/rv32_fetch_stage.sv
// ----------------------------------------
// Fetch stage
// Presents pc on the instruction port and
// latches the returned word for decode
// ----------------------------------------
`timescale 1ns/1ps

module rv32_fetch_stage (
    input  logic                          clk,
    input  logic                          resetn,
    input  rv32_pkg::rv32_word            pc,
    input  logic                          stall,
    input  logic                          flush,
    input  rv32_pkg::rv_instr_t           instr,
    input  logic                          ready,
    output rv32_pkg::rv32_word            addr,
    output rv32_pkg::fetch_buffer_data_t  fetch_data
);

    assign addr = pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_data.valid <= 1'b0;
        end else if (flush) begin
            // Wrong-path word is dropped
            fetch_data.valid <= 1'b0;
        end else if (!stall) begin
            // No word this cycle when the memory is not ready
            fetch_data.valid <= ready;
            fetch_data.pc    <= pc;
            fetch_data.instr <= instr;
        end
    end

    // A jump from execute always kills the word behind it
    a_flush_kills_fetch: assert property (
        @(posedge clk) disable iff (!resetn)
        flush |=> !fetch_data.valid
    ) else $error("fetch record valid after flush");

endmodule

// File: hw/rv32_register_file.sv
// ----------------------------------------
// Integer register file, 2 read / 1 write
// Write-first reads, x0 hard-wired to zero
// ----------------------------------------
`timescale 1ns/1ps
`include "rv32_cfg.svh"

module rv32_register_file (
    input  logic                 clk,
    input  logic                 resetn,
    input  rv32_pkg::rv_reg_id_t r1,
    input  rv32_pkg::rv_reg_id_t r2,
    input  rv32_pkg::rv_reg_id_t rw,
    input  logic                 write,
    input  rv32_pkg::rv32_word   d,
    output rv32_pkg::rv32_word   o1,
    output rv32_pkg::rv32_word   o2
);
    import rv32_pkg::*;

    rv32_word regs [`RV32_NUM_REGS];

    // Bypass the word being written this cycle
    function automatic rv32_word read_port(input rv_reg_id_t id);
        rv32_word value;
        if (id == '0) begin
            value = '0;
        end else if (write && rw == id) begin
            value = d;
        end else begin
            value = regs[id];
        end
        return value;
    endfunction

    always_comb begin
        o1 = read_port(r1);
        o2 = read_port(r2);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `RV32_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write && rw != '0) begin
            regs[rw] <= d;
        end
    end

endmodule

// File: hw/rv32_pkg.sv
// ----------------------------------------
// Shared types of the RV32 pipeline
// Instruction views, opcodes, ALU ops and
// the records passed between stages
// ----------------------------------------
package rv32_pkg;

    typedef logic [31:0] rv32_word;
    typedef logic [4:0]  rv_reg_id_t;

    // Register-register layout, also the source of S/B/U/J immediate bits
    typedef struct packed {
        logic [6:0] funct7;
        rv_reg_id_t rs2;
        rv_reg_id_t rs1;
        logic [2:0] funct3;
        rv_reg_id_t rd;
        logic [6:0] opcode;
    } rv_r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        rv_reg_id_t  rs1;
        logic [2:0]  funct3;
        rv_reg_id_t  rd;
        logic [6:0]  opcode;
    } rv_i_view_t;

    typedef union packed {
        rv_r_view_t r;
        rv_i_view_t i;
    } rv_instr_t;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } rv_opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic      valid;
        rv32_word  pc;
        rv_instr_t instr;
    } fetch_buffer_data_t;

    typedef struct packed {
        logic       valid;
        rv32_word   pc;
        rv_reg_id_t rd;
        logic       reg_write;
        alu_op_e    alu_op;
        logic       use_imm;
        rv32_word   op1;
        rv32_word   op2;
        rv32_word   imm;
        logic       is_branch;
        logic       branch_ne;
        logic       is_jal;
        logic       is_load;
        logic       is_store;
    } decoded_buffer_data_t;

    // Result doubles as the data RAM address for loads and stores
    typedef struct packed {
        logic       valid;
        rv_reg_id_t rd;
        logic       reg_write;
        logic       is_load;
        logic       is_store;
        rv32_word   result;
        rv32_word   store_data;
    } exec_buffer_data_t;

    typedef struct packed {
        logic       valid;
        rv_reg_id_t rd;
        logic       reg_write;
        rv32_word   result;
    } mem_buffer_data_t;

endpackage

// File: hw/rv32_cfg.svh
// ----------------------------------------
// Build-time sizes for the RV32 core
// Include in any module that needs them
// ----------------------------------------
`ifndef RV32_CFG_SVH
`define RV32_CFG_SVH

// First fetch address after reset
`define RV32_RESET_PC 32'h0000_0000

// Data RAM depth in words, must be a power of two
`define RV32_DMEM_WORDS 64

// Architectural integer registers
`define RV32_NUM_REGS 32

`endif
